// ==== alu.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// 8-bit combinational ALU, top level
// bundles the inputs for the function units and collects result and flags
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

module alu (
    input  wire alu_pkg::data_t   a,
    input  wire alu_pkg::data_t   b,
    input  wire alu_pkg::alu_op_t op,
    input  wire logic             carry_in,
    output alu_pkg::data_t        result,
    output logic                  flag_c,
    output logic                  flag_z,
    output logic                  flag_n,
    output logic                  flag_o,
    output logic                  flag_gt,
    output logic                  flag_lt,
    output logic                  flag_eq,
    output logic                  flag_ne
);
    import alu_pkg::*;

    // the top level is the only source of the operand bundle
    alu_operands_if operands ();

    assign operands.a        = a;
    assign operands.b        = b;
    assign operands.op       = op;
    assign operands.carry_in = carry_in;

    // each unit returns its own 9-bit answer, carry on top
    wide_t sum;
    wide_t quotient;
    wide_t shifted;
    logic  overflow;
    logic  div_zero;

    alu_add_sub add_sub_i (
        .operands (operands),
        .sum      (sum),
        .overflow (overflow)
    );

    alu_mul_div mul_div_i (
        .operands (operands),
        .quotient (quotient),
        .div_zero (div_zero)
    );

    alu_shift_logic shift_logic_i (
        .operands (operands),
        .shifted  (shifted)
    );

    alu_flag_gen flag_gen_i (
        .operands (operands),
        .sum      (sum),
        .quotient (quotient),
        .shifted  (shifted),
        .overflow (overflow),
        .div_zero (div_zero),
        .result   (result),
        .flag_c   (flag_c),
        .flag_z   (flag_z),
        .flag_n   (flag_n),
        .flag_o   (flag_o),
        .flag_gt  (flag_gt),
        .flag_lt  (flag_lt),
        .flag_eq  (flag_eq),
        .flag_ne  (flag_ne)
    );

endmodule

`default_nettype wire

// ==== alu_add_sub.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// ALU arithmetic unit
// pass, negate, increment, decrement, add and subtract in 9 bits so
// that bit 8 carries the carry or borrow, plus signed overflow detection
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

module alu_add_sub (
    alu_operands_if.unit   operands,
    output alu_pkg::wide_t sum,
    output logic           overflow
);
    import alu_pkg::*;

    // zero extended copies so every sum keeps its carry in bit 8
    wide_t a_w;
    wide_t b_w;
    wide_t c_w;

    assign a_w = {1'b0, operands.a};
    assign b_w = {1'b0, operands.b};
    assign c_w = {8'b0, operands.carry_in};

    // adding two values of the same sign must not flip the sign
    function automatic logic add_ovf(input logic l, input logic r, input logic res);
        return (l == r) && (res != l);
    endfunction

    // subtracting values of opposite sign must keep the minuend's sign
    function automatic logic sub_ovf(input logic m, input logic s, input logic res);
        return (m != s) && (res != m);
    endfunction

    always_comb begin
        sum      = '0;
        overflow = 1'b0;
        case (operands.op)
            op_zero:  sum = '0;
            op_a:     sum = a_w;
            op_b:     sum = b_w;
            // negate is 0 minus the operand, so any non-zero value borrows
            op_neg_a: sum = 9'd0 - a_w;
            op_neg_b: sum = 9'd0 - b_w;
            // these set carry on wrap but never consume it
            op_a_inc: sum = a_w + 9'd1;
            op_b_inc: sum = b_w + 9'd1;
            op_a_dec: sum = a_w - 9'd1;
            op_b_dec: sum = b_w - 9'd1;
            op_a_plus_b, op_a_plus_b_c: begin
                // carry_in is zero-extended so it adds only for the _c form
                sum = (operands.op == op_a_plus_b_c) ? a_w + b_w + c_w : a_w + b_w;
                overflow = add_ovf(operands.a[sign_bit], operands.b[sign_bit],
                                   sum[sign_bit]);
            end
            op_a_minus_b, op_a_minus_b_signed, op_a_minus_b_c: begin
                // the signed compare form computes exactly like A-B
                sum = (operands.op == op_a_minus_b_c) ? a_w - b_w - c_w : a_w - b_w;
                overflow = sub_ovf(operands.a[sign_bit], operands.b[sign_bit],
                                   sum[sign_bit]);
            end
            op_b_minus_a, op_b_minus_a_c: begin
                sum = (operands.op == op_b_minus_a_c) ? b_w - a_w - c_w : b_w - a_w;
                overflow = sub_ovf(operands.b[sign_bit], operands.a[sign_bit],
                                   sum[sign_bit]);
            end
            // codes 16 and up belong to the other units
            default: sum = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== alu_flag_gen.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// ALU result select and flag generation
// picks the unit result by opcode group and forms the eight flags
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

module alu_flag_gen (
    alu_operands_if.unit   operands,
    input  alu_pkg::wide_t sum,
    input  alu_pkg::wide_t quotient,
    input  alu_pkg::wide_t shifted,
    input  logic           overflow,
    input  logic           div_zero,
    output alu_pkg::data_t result,
    output logic           flag_c,
    output logic           flag_z,
    output logic           flag_n,
    output logic           flag_o,
    output logic           flag_gt,
    output logic           flag_lt,
    output logic           flag_eq,
    output logic           flag_ne
);
    import alu_pkg::*;

    wide_t selected;
    logic  signed_cmp;

    always_comb begin
        selected = '0;
        flag_o   = 1'b0;
        case (operands.op[4:3])
            // the arithmetic group fills both of the lower quarters
            op_group_arith, op_group_arith + 2'd1: begin
                selected = sum;
                flag_o   = overflow;
            end
            op_group_muldiv: begin
                // shifts share this group, each unit is 0 outside its own codes
                selected = quotient | shifted;
                flag_o   = div_zero;
            end
            op_group_logic: selected = shifted;
            default: selected = '0;
        endcase
    end

    assign result = selected[7:0];
    assign flag_c = selected[8];
    assign flag_z = (selected[7:0] == 8'd0);
    assign flag_n = selected[sign_bit];

    // magnitude compare is unsigned except for the signed subtract form
    assign signed_cmp = (operands.op == op_a_minus_b_signed);
    assign flag_gt = signed_cmp ? ($signed(operands.a) > $signed(operands.b))
                                : (operands.a > operands.b);
    assign flag_lt = signed_cmp ? ($signed(operands.a) < $signed(operands.b))
                                : (operands.a < operands.b);

    // equality does not depend on signedness
    assign flag_eq = (operands.a == operands.b);
    assign flag_ne = (operands.a != operands.b);

endmodule

`default_nettype wire

// ==== alu_mul_div.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// ALU multiply and divide unit
// unsigned 8x8 multiply with low or high byte out, unsigned divide and
// modulo, a zero divisor yields 0 with carry and the divide-by-zero bit
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

module alu_mul_div (
    alu_operands_if.unit   operands,
    output alu_pkg::wide_t quotient,
    output logic           div_zero
);
    import alu_pkg::*;

    // one shared multiplier feeds both the low and the high byte ops
    product_t product;
    logic     b_is_zero;

    assign product   = product_t'(operands.a) * product_t'(operands.b);
    assign b_is_zero = (operands.b == 8'd0);

    // only divide and modulo care about a zero divisor
    assign div_zero = b_is_zero && (operands.op == op_div || operands.op == op_mod);

    always_comb begin
        quotient = '0;
        case (operands.op)
            // carry flags that the product spilled into the high byte
            op_mul_lo: quotient = {(product[15:8] != 8'd0), product[7:0]};
            op_mul_hi: quotient = {1'b0, product[15:8]};
            op_div: begin
                if (b_is_zero) quotient = {1'b1, 8'd0};
                else quotient = {1'b0, operands.a / operands.b};
            end
            op_mod: begin
                if (b_is_zero) quotient = {1'b1, 8'd0};
                else quotient = {1'b0, operands.a % operands.b};
            end
            // everything else, the shifts included, is somebody else's job
            default: quotient = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== alu_operands_if.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// ALU operand bundle
// carries both operands, the opcode and carry in to every function unit
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

interface alu_operands_if;

    // all plain levels, there is no handshake on this bundle
    alu_pkg::data_t   a;
    alu_pkg::data_t   b;
    alu_pkg::alu_op_t op;
    logic             carry_in;

    // the top level drives the bundle
    modport source (output a, output b, output op, output carry_in);
    // the function units and the flag generator only look at it
    modport unit (input a, input b, input op, input carry_in);

endinterface

`default_nettype wire

// ==== alu_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// shared definitions for the 8-bit hobby CPU ALU
// operand and result types, opcode numbering and opcode group codes
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package alu_pkg;

    // one operand or result byte
    typedef logic [7:0] data_t;
    // unit result, bit 8 holds the carry or borrow
    typedef logic [8:0] wide_t;
    // full multiplier output
    typedef logic [15:0] product_t;
    // operation code as it arrives from the microcode
    typedef logic [4:0] alu_op_t;

    // the sign of a two's complement byte lives here
    localparam int sign_bit = 7;

    // op[4:3] picks the group, the arithmetic group spans codes 0 to 15
    localparam logic [1:0] op_group_arith  = 2'd0;
    localparam logic [1:0] op_group_muldiv = 2'd2;
    localparam logic [1:0] op_group_logic  = 2'd3;

    // pass and unary arithmetic
    localparam alu_op_t op_zero  = 5'd0;
    localparam alu_op_t op_a     = 5'd1;
    localparam alu_op_t op_b     = 5'd2;
    localparam alu_op_t op_neg_a = 5'd3;
    localparam alu_op_t op_neg_b = 5'd4;
    localparam alu_op_t op_a_inc = 5'd5;
    localparam alu_op_t op_b_inc = 5'd6;
    localparam alu_op_t op_a_dec = 5'd7;
    localparam alu_op_t op_b_dec = 5'd8;

    // two operand add and subtract, the _c forms consume carry_in
    localparam alu_op_t op_a_plus_b         = 5'd9;
    localparam alu_op_t op_a_minus_b        = 5'd10;
    localparam alu_op_t op_b_minus_a        = 5'd11;
    localparam alu_op_t op_a_minus_b_signed = 5'd12;
    localparam alu_op_t op_a_plus_b_c       = 5'd13;
    localparam alu_op_t op_a_minus_b_c      = 5'd14;
    localparam alu_op_t op_b_minus_a_c      = 5'd15;

    // multiply, divide and the shifts share group 2
    localparam alu_op_t op_mul_lo = 5'd16;
    localparam alu_op_t op_mul_hi = 5'd17;
    localparam alu_op_t op_div    = 5'd18;
    localparam alu_op_t op_mod    = 5'd19;
    localparam alu_op_t op_shl    = 5'd20;
    localparam alu_op_t op_shr    = 5'd21;

    // bitwise ops, codes 22 to 24 and 27 to 31 are unused
    localparam alu_op_t op_a_and_b = 5'd25;
    localparam alu_op_t op_a_or_b  = 5'd26;

endpackage

`default_nettype wire

// ==== alu_shift_logic.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// ALU shift and logic unit
// shift left and logical shift right through carry by b places,
// bitwise AND and OR
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

module alu_shift_logic (
    alu_operands_if.unit   operands,
    output alu_pkg::wide_t shifted
);
    import alu_pkg::*;

    // carry_in enters below bit 0 on a left shift and above bit 7 on a right shift
    wide_t shl_src;
    wide_t shr_src;
    wide_t shl_out;
    wide_t shr_out;
    wide_t shr_last;
    data_t amount_less_one;

    assign shl_src         = {operands.a, operands.carry_in};
    assign shr_src         = {operands.carry_in, operands.a};
    assign amount_less_one = operands.b - 8'd1;

    // the first place of the left shift is taken by the 9-bit framing itself
    assign shl_out = shl_src << amount_less_one;
    assign shr_out = shr_src >> operands.b;

    // last bit shifted out on the right, it is 0 once b goes past 9
    assign shr_last = shr_src >> amount_less_one;

    always_comb begin
        shifted = '0;
        case (operands.op)
            op_shl: begin
                if (operands.b == 8'd0) shifted = {1'b0, operands.a};
                else shifted = shl_out;
            end
            op_shr: begin
                // a zero shift leaves a alone with carry clear
                if (operands.b == 8'd0) shifted = {1'b0, operands.a};
                else shifted = {shr_last[0], shr_out[7:0]};
            end
            op_a_and_b: shifted = {1'b0, operands.a & operands.b};
            op_a_or_b:  shifted = {1'b0, operands.a | operands.b};
            // XOR, NOT, rotates, arithmetic shift right and BCD are not built
            default: shifted = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== run.sh ====
#!/usr/bin/env bash
# Build the ALU testbench with Verilator, run it and scan the log.

cd "$(dirname "$0")" || exit 1

verilator --binary --top-module tb_alu -f src.f -o tb_alu_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_alu_sim > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

grep -q "Errors found" sim.log
grep_status=$?
if [ $grep_status -eq 0 ]; then
    exit 1
elif [ $grep_status -ne 1 ]; then
    echo "could not search sim.log"
    exit 1
fi
exit 0

// ==== src.f ====
alu_pkg.sv
alu_operands_if.sv
alu_add_sub.sv
alu_mul_div.sv
alu_shift_logic.sv
alu_flag_gen.sv
alu.sv
tb_alu.sv

// ==== tb_alu.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench for the 8-bit combinational ALU
// runs a directed table, then an LFSR driven sweep checked against a
// reference model built from the opcode rules
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

module tb_alu;
    import alu_pkg::*;

    // the flags field of a vector reads c z n o gt lt eq ne from the top bit down
    typedef struct packed {
        data_t      a;
        data_t      b;
        alu_op_t    op;
        logic       cin;
        data_t      res;
        logic [7:0] flags;
    } row_t;

    logic        clk;
    logic        reset;
    data_t       a;
    data_t       b;
    alu_op_t     op;
    logic        carry_in;
    data_t       result;
    logic        flag_c;
    logic        flag_z;
    logic        flag_n;
    logic        flag_o;
    logic        flag_gt;
    logic        flag_lt;
    logic        flag_eq;
    logic        flag_ne;
    logic [15:0] lfsr;
    row_t        rows [$];
    string       flag_names [7:0] = '{"c", "z", "n", "o", "gt", "lt", "eq", "ne"};

    alu alu_i (
        .a (a), .b (b), .op (op), .carry_in (carry_in), .result (result),
        .flag_c (flag_c), .flag_z (flag_z), .flag_n (flag_n), .flag_o (flag_o),
        .flag_gt (flag_gt), .flag_lt (flag_lt), .flag_eq (flag_eq), .flag_ne (flag_ne)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    // the operands stay at zero while reset is asserted
    initial begin
        reset <= 1'b1;
        repeat (4) @(posedge clk);
        reset <= 1'b0;
    end

    task automatic stop_on_error();
        $display("Errors found");
        $fatal(1, "simulation stopped at the first failing check");
    endtask

    task automatic check_data(input data_t got, input data_t exp, input alu_op_t code);
        if (got !== exp) begin
            $display("ERR %0t: op %0d result %02h expected %02h", $time, code, got, exp);
            stop_on_error();
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string name,
                              input alu_op_t code);
        if (got !== exp) begin
            $display("ERR %0t: op %0d flag_%s is %b expected %b", $time, code, name, got, exp);
            stop_on_error();
        end
    endtask

    // inputs change on the falling edge and the outputs have settled by the rising edge
    task automatic apply_and_check(input row_t r);
        logic [7:0] got_flags;
        @(negedge clk);
        a = r.a;
        b = r.b;
        op = r.op;
        carry_in = r.cin;
        @(posedge clk);
        got_flags = {flag_c, flag_z, flag_n, flag_o, flag_gt, flag_lt, flag_eq, flag_ne};
        check_data(result, r.res, r.op);
        for (int i = 7; i >= 0; i--) begin
            check_flag(got_flags[i], r.flags[i], flag_names[i], r.op);
        end
    endtask

    // galois LFSR with taps at 16 14 13 and 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
    endfunction

    // one LFSR step per bit taken
    task automatic draw_bits(input int count, output data_t value);
        value = '0;
        for (int i = 0; i < count; i++) begin
            value = {value[6:0], lfsr[0]};
            lfsr = lfsr_step(lfsr);
        end
    endtask

    // the reference model takes carry and overflow from integer ranges
    function automatic row_t model_alu(input data_t x, input data_t y, input alu_op_t code,
                                       input logic cin);
        row_t       r;
        int         ux;
        int         uy;
        int         sx;
        int         sy;
        int         ci;
        int         u;
        int         s;
        logic       c;
        logic       o;
        logic       add_sub;
        logic       gt;
        logic       lt;
        logic [8:0] v;
        ux = int'(x);
        uy = int'(y);
        sx = int'($signed(x));
        sy = int'($signed(y));
        ci = (code == op_a_plus_b_c || code == op_a_minus_b_c || code == op_b_minus_a_c)
             ? int'(cin) : 0;
        u = 0;
        s = 0;
        c = 1'b0;
        o = 1'b0;
        add_sub = 1'b0;
        case (code)
            op_a:     u = ux;
            op_b:     u = uy;
            op_neg_a: u = -ux;
            op_neg_b: u = -uy;
            op_a_inc: u = ux + 1;
            op_b_inc: u = uy + 1;
            op_a_dec: u = ux - 1;
            op_b_dec: u = uy - 1;
            op_a_plus_b, op_a_plus_b_c: begin
                u = ux + uy + ci;
                s = sx + sy + ci;
                add_sub = 1'b1;
            end
            op_a_minus_b, op_a_minus_b_signed, op_a_minus_b_c: begin
                u = ux - uy - ci;
                s = sx - sy - ci;
                add_sub = 1'b1;
            end
            op_b_minus_a, op_b_minus_a_c: begin
                u = uy - ux - ci;
                s = sy - sx - ci;
                add_sub = 1'b1;
            end
            op_mul_lo: begin
                u = (ux * uy) % 256;
                c = (ux * uy) > 255;
            end
            op_mul_hi: u = (ux * uy) / 256;
            op_div, op_mod: begin
                // a zero divisor leaves 0 with carry and overflow set
                if (uy == 0) begin
                    c = 1'b1;
                    o = 1'b1;
                end else begin
                    u = (code == op_div) ? ux / uy : ux % uy;
                end
            end
            op_shl: begin
                // carry in enters bit 0 on the first single-bit step only
                v = {1'b0, x};
                for (int i = 0; i < uy; i++) begin
                    v = {v[7:0], ((i == 0) ? cin : 1'b0)};
                end
                u = int'(v[7:0]);
                c = v[8];
            end
            op_shr: begin
                // carry in sits above bit 7 and the last bit out becomes the carry
                v = {cin, x};
                for (int i = 0; i < uy; i++) begin
                    c = v[0];
                    v = v >> 1;
                end
                u = int'(v[7:0]);
            end
            op_a_and_b: u = ux & uy;
            op_a_or_b:  u = ux | uy;
            default:    u = 0;
        endcase
        // below code 16 the carry is any excursion outside 0 to 255
        if (code < 5'd16) c = (u < 0) || (u > 255);
        o = o || (add_sub && ((s > 127) || (s < -128)));
        gt = (code == op_a_minus_b_signed) ? (sx > sy) : (ux > uy);
        lt = (code == op_a_minus_b_signed) ? (sx < sy) : (ux < uy);
        r.a = x;
        r.b = y;
        r.op = code;
        r.cin = cin;
        r.res = u[7:0];
        r.flags = {c, (u[7:0] == 8'd0), u[7], o, gt, lt, (ux == uy), (ux != uy)};
        return r;
    endfunction

    // each directed vector holds a, b, op, carry in, the result and the flags c z n o gt lt eq ne
    task automatic fill_table();
        rows.push_back('{8'h00, 8'h00, op_zero, 1'b0, 8'h00, 8'b0100_0010});
        rows.push_back('{8'h01, 8'h80, op_b, 1'b0, 8'h80, 8'b0010_0101});
        rows.push_back('{8'h01, 8'h01, op_neg_a, 1'b0, 8'hff, 8'b1010_0010});
        rows.push_back('{8'hff, 8'h00, op_a_inc, 1'b0, 8'h00, 8'b1100_1001});
        rows.push_back('{8'h00, 8'h7f, op_b_inc, 1'b0, 8'h80, 8'b0010_0101});
        rows.push_back('{8'h00, 8'h00, op_a_dec, 1'b0, 8'hff, 8'b1010_0010});
        rows.push_back('{8'h03, 8'h01, op_b_dec, 1'b0, 8'h00, 8'b0100_1001});
        // 127+1 overflows and the _c form with carry clear must match plain add
        rows.push_back('{8'h7f, 8'h01, op_a_plus_b, 1'b0, 8'h80, 8'b0011_1001});
        rows.push_back('{8'h7f, 8'h01, op_a_plus_b_c, 1'b0, 8'h80, 8'b0011_1001});
        rows.push_back('{8'hff, 8'h00, op_a_plus_b_c, 1'b1, 8'h00, 8'b1100_1001});
        rows.push_back('{8'h80, 8'h80, op_a_plus_b, 1'b0, 8'h00, 8'b1101_0010});
        rows.push_back('{8'h80, 8'h01, op_a_minus_b, 1'b0, 8'h7f, 8'b0001_1001});
        rows.push_back('{8'h01, 8'h02, op_a_minus_b, 1'b0, 8'hff, 8'b1010_0101});
        rows.push_back('{8'h01, 8'h05, op_b_minus_a, 1'b0, 8'h04, 8'b0000_0101});
        rows.push_back('{8'h05, 8'h02, op_a_minus_b_c, 1'b1, 8'h02, 8'b0000_1001});
        rows.push_back('{8'h05, 8'h05, op_b_minus_a_c, 1'b1, 8'hff, 8'b1010_0010});
        rows.push_back('{8'h10, 8'h10, op_mul_lo, 1'b0, 8'h00, 8'b1100_0010});
        rows.push_back('{8'h0c, 8'h0b, op_mul_lo, 1'b0, 8'h84, 8'b0010_1001});
        rows.push_back('{8'hff, 8'hff, op_mul_hi, 1'b0, 8'hfe, 8'b0010_0010});
        rows.push_back('{8'h64, 8'h07, op_div, 1'b0, 8'h0e, 8'b0000_1001});
        rows.push_back('{8'h2a, 8'h00, op_div, 1'b0, 8'h00, 8'b1101_1001});
        rows.push_back('{8'h64, 8'h07, op_mod, 1'b0, 8'h02, 8'b0000_1001});
        rows.push_back('{8'h00, 8'h00, op_mod, 1'b0, 8'h00, 8'b1101_0010});
        rows.push_back('{8'h81, 8'h00, op_shl, 1'b1, 8'h81, 8'b0010_1001});
        rows.push_back('{8'h81, 8'h01, op_shl, 1'b0, 8'h02, 8'b1000_1001});
        rows.push_back('{8'h81, 8'h08, op_shl, 1'b1, 8'h80, 8'b1010_1001});
        rows.push_back('{8'h81, 8'h08, op_shl, 1'b0, 8'h00, 8'b1100_1001});
        rows.push_back('{8'h81, 8'h0a, op_shl, 1'b1, 8'h00, 8'b0100_1001});
        rows.push_back('{8'h81, 8'h00, op_shr, 1'b0, 8'h81, 8'b0010_1001});
        rows.push_back('{8'h81, 8'h01, op_shr, 1'b1, 8'hc0, 8'b1010_1001});
        rows.push_back('{8'h81, 8'h08, op_shr, 1'b1, 8'h01, 8'b1000_1001});
        rows.push_back('{8'h81, 8'h08, op_shr, 1'b0, 8'h00, 8'b1100_1001});
        rows.push_back('{8'h81, 8'h0a, op_shr, 1'b1, 8'h00, 8'b0100_1001});
        rows.push_back('{8'hf0, 8'h3c, op_a_and_b, 1'b0, 8'h30, 8'b0000_1001});
        rows.push_back('{8'hf0, 8'h3c, op_a_or_b, 1'b0, 8'hfc, 8'b0010_1001});
        // -2 against 3 flips gt and lt once the compare turns signed
        rows.push_back('{8'hfe, 8'h03, op_a_minus_b_signed, 1'b0, 8'hfb, 8'b0010_0101});
        rows.push_back('{8'hfe, 8'h03, op_a_minus_b, 1'b0, 8'hfb, 8'b0010_1001});
        rows.push_back('{8'h03, 8'hfe, op_a_minus_b_signed, 1'b0, 8'h05, 8'b1000_1001});
        // unbuilt codes such as XOR, the rotates and BCD give a cleared result
        rows.push_back('{8'h55, 8'haa, 5'd22, 1'b1, 8'h00, 8'b0100_0101});
        rows.push_back('{8'h55, 8'haa, 5'd24, 1'b1, 8'h00, 8'b0100_0101});
        rows.push_back('{8'h55, 8'haa, 5'd29, 1'b1, 8'h00, 8'b0100_0101});
    endtask

    initial begin
        int    wait_cycles;
        data_t rand_a;
        data_t rand_b;
        data_t rand_c;
        a = '0;
        b = '0;
        op = op_zero;
        carry_in = 1'b0;
        lfsr = 16'd82;
        fill_table();
        // give up if reset never drops
        wait_cycles = 0;
        while (reset !== 1'b0) begin
            @(posedge clk);
            wait_cycles++;
            if (wait_cycles > 16) begin
                $display("timeout: reset still asserted after 16 clock cycles");
                stop_on_error();
            end
        end
        foreach (rows[i]) begin
            apply_and_check(rows[i]);
        end
        // the opcode walks through all 32 codes twice
        for (int step = 0; step < 64; step++) begin
            draw_bits(8, rand_a);
            draw_bits(8, rand_b);
            draw_bits(1, rand_c);
            apply_and_check(model_alu(rand_a, rand_b, alu_op_t'(step), rand_c[0]));
        end
        $display("No errors");
        $finish;
    end

endmodule

`default_nettype wire
